// File: hdl/lane_macros.svh
`ifndef LANE_MACROS_SVH
`define LANE_MACROS_SVH

// -------------------------------------------------------------------
// Lane geometry
// -------------------------------------------------------------------

// Engine ports on one lane
`define LANE_NUM_ENGINES 4

// Enough bits to name every engine
`define LANE_ENGINE_ID_W 2

`define LANE_ADDR_W 32
`define LANE_DATA_W 32

// -------------------------------------------------------------------
// FIFO sizing
// -------------------------------------------------------------------

`define LANE_FIFO_DEPTH 16

// Almost-full from this fill level up, leaves slack for late pushes
`define LANE_PROG_THRESH 12

`endif

// File: hdl/lane_pkg.sv
`include "lane_macros.svh"

package lane_pkg;

    // Memory opcodes
    typedef enum logic {
        MEM_CMD_READ  = 1'b0,
        MEM_CMD_WRITE = 1'b1
    } mem_cmd_e;

    // Index of an engine within the lane
    typedef logic [`LANE_ENGINE_ID_W-1:0] engine_id_t;

    // One memory packet, 67 bits with the default widths
    // Requests and responses share the same layout
    typedef struct packed {
        engine_id_t             id;
        mem_cmd_e               cmd;
        logic [`LANE_ADDR_W-1:0] addr;
        logic [`LANE_DATA_W-1:0] data;
    } mem_packet_t;

endpackage : lane_pkg

// File: hdl/lane_sync_fifo.sv
`timescale 1ns/1ns
`include "lane_macros.svh"

module lane_sync_fifo #(
    parameter int DEPTH = `LANE_FIFO_DEPTH
) (
    input  logic                  ap_clk,
    input  logic                  areset_lane_template,
    input  logic                  push_i,
    input  logic                  pop_i,
    input  lane_pkg::mem_packet_t din_i,
    output lane_pkg::mem_packet_t dout_o,
    output logic                  dout_valid_o,
    output logic                  empty_o,
    output logic                  full_o,
    output logic                  almost_full_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    lane_pkg::mem_packet_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    // Requests beyond the limits are dropped here
    assign do_push = push_i & ~full_o;
    assign do_pop  = pop_i & ~empty_o;

    assign empty_o       = (count == '0);
    assign full_o        = (count == CNT_W'(DEPTH));
    assign almost_full_o = (count >= CNT_W'(`LANE_PROG_THRESH));

    // -------------------------------------------------------------------
    // Storage and registered read port
    // -------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= din_i;
        end
        if (do_pop) begin
            dout_o <= mem[rd_ptr];
        end
    end

    // -------------------------------------------------------------------
    // Pointers and occupancy
    // -------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_lane_template) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            count        <= '0;
            dout_valid_o <= 1'b0;
        end else begin
            dout_valid_o <= do_pop;
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leave the count alone
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    a_no_push_full: assert property (@(posedge ap_clk) disable iff (areset_lane_template)
        push_i |-> !full_o)
        else $error("lane_sync_fifo: push while full");

    a_no_pop_empty: assert property (@(posedge ap_clk) disable iff (areset_lane_template)
        pop_i |-> !empty_o)
        else $error("lane_sync_fifo: pop while empty");

endmodule : lane_sync_fifo

// File: hdl/mem_request_arbiter.sv
`timescale 1ns/1ns
`include "lane_macros.svh"

module mem_request_arbiter (
    input  logic                         ap_clk,
    input  logic                         areset_lane_template,
    input  logic [`LANE_NUM_ENGINES-1:0] eng_req_valid_i,
    input  lane_pkg::mem_packet_t        eng_req_packet_i [`LANE_NUM_ENGINES],
    output logic [`LANE_NUM_ENGINES-1:0] eng_req_pop_o,
    input  logic                         mem_req_ready_i,
    output logic                         mem_req_valid_o,
    output lane_pkg::mem_packet_t        mem_req_packet_o,
    output logic                         req_empty_o,
    output logic                         read_issued_o
);

    import lane_pkg::*;

    engine_id_t                   last_q;
    engine_id_t                   grant_idx;
    logic [`LANE_NUM_ENGINES-1:0] grant;
    logic                         grant_any;
    mem_packet_t                  push_pkt;
    logic                         fifo_pop;
    logic                         fifo_empty;
    logic                         fifo_almost_full;

    // -------------------------------------------------------------------
    // Round-robin pick
    // -------------------------------------------------------------------
    // Search starts one past the last winner and wraps around
    always_comb begin
        int idx;
        grant     = '0;
        grant_idx = last_q;
        for (int off = 1; off <= `LANE_NUM_ENGINES; off++) begin
            idx = (int'(last_q) + off) % `LANE_NUM_ENGINES;
            if (grant == '0 && eng_req_valid_i[idx] && !fifo_almost_full) begin
                grant[idx] = 1'b1;
                grant_idx  = engine_id_t'(idx);
            end
        end
    end

    assign grant_any     = |grant;
    assign eng_req_pop_o = grant;

    // Winner's index overwrites whatever id the engine sent
    always_comb begin
        push_pkt    = eng_req_packet_i[grant_idx];
        push_pkt.id = grant_idx;
    end

    // Engine 0 gets first turn after reset
    always_ff @(posedge ap_clk) begin
        if (areset_lane_template) begin
            last_q <= engine_id_t'(`LANE_NUM_ENGINES - 1);
        end else if (grant_any) begin
            last_q <= grant_idx;
        end
    end

    // -------------------------------------------------------------------
    // Request FIFO toward memory
    // -------------------------------------------------------------------
    assign fifo_pop = mem_req_ready_i & ~fifo_empty;

    lane_sync_fifo #(
        .DEPTH(`LANE_FIFO_DEPTH)
    ) u_req_fifo (
        .ap_clk              (ap_clk),
        .areset_lane_template(areset_lane_template),
        .push_i              (grant_any),
        .pop_i               (fifo_pop),
        .din_i               (push_pkt),
        .dout_o              (mem_req_packet_o),
        .dout_valid_o        (mem_req_valid_o),
        .empty_o             (fifo_empty),
        .full_o              (),
        .almost_full_o       (fifo_almost_full)
    );

    // Nothing waiting at the engines, in the FIFO or on its output register
    assign req_empty_o   = fifo_empty & ~mem_req_valid_o & ~(|eng_req_valid_i);
    assign read_issued_o = mem_req_valid_o & (mem_req_packet_o.cmd == MEM_CMD_READ);

    a_grant_onehot: assert property (@(posedge ap_clk) disable iff (areset_lane_template)
        $onehot0(eng_req_pop_o))
        else $error("mem_request_arbiter: more than one engine granted");

endmodule : mem_request_arbiter

// File: hdl/mem_response_router.sv
`timescale 1ns/1ns
`include "lane_macros.svh"

module mem_response_router (
    input  logic                         ap_clk,
    input  logic                         areset_lane_template,
    input  logic                         mem_rsp_valid_i,
    input  lane_pkg::mem_packet_t        mem_rsp_packet_i,
    output logic                         mem_rsp_ready_o,
    input  logic [`LANE_NUM_ENGINES-1:0] eng_rsp_ready_i,
    output logic [`LANE_NUM_ENGINES-1:0] eng_rsp_valid_o,
    output lane_pkg::mem_packet_t        eng_rsp_packet_o,
    output logic                         rsp_empty_o,
    output logic                         read_returned_o
);

    import lane_pkg::*;

    mem_packet_t head_pkt;
    logic        head_fresh;
    logic        head_held_q;
    logic        head_avail;
    logic        deliver;
    logic        fifo_pop;
    logic        fifo_empty;
    logic        fifo_almost_full;

    assign mem_rsp_ready_o = ~fifo_almost_full;

    lane_sync_fifo #(
        .DEPTH(`LANE_FIFO_DEPTH)
    ) u_rsp_fifo (
        .ap_clk              (ap_clk),
        .areset_lane_template(areset_lane_template),
        .push_i              (mem_rsp_valid_i),
        .pop_i               (fifo_pop),
        .din_i               (mem_rsp_packet_i),
        .dout_o              (head_pkt),
        .dout_valid_o        (head_fresh),
        .empty_o             (fifo_empty),
        .full_o              (),
        .almost_full_o       (fifo_almost_full)
    );

    // -------------------------------------------------------------------
    // Head slot
    // -------------------------------------------------------------------
    // FIFO output register is the head; it stays there until its engine is ready
    assign head_avail = head_fresh | head_held_q;
    assign deliver    = head_avail & eng_rsp_ready_i[head_pkt.id];

    // Refill only once the head slot frees up, so a blocked id stalls the rest
    assign fifo_pop = ~fifo_empty & (~head_avail | deliver);

    always_ff @(posedge ap_clk) begin
        if (areset_lane_template) begin
            head_held_q <= 1'b0;
        end else begin
            head_held_q <= head_avail & ~deliver;
        end
    end

    // One-hot valid toward the engine named by the id
    always_comb begin
        eng_rsp_valid_o              = '0;
        eng_rsp_valid_o[head_pkt.id] = deliver;
    end

    assign eng_rsp_packet_o = head_pkt;
    assign read_returned_o  = deliver & (head_pkt.cmd == MEM_CMD_READ);
    assign rsp_empty_o      = fifo_empty & ~head_avail & ~mem_rsp_valid_i;

    a_push_when_ready: assert property (@(posedge ap_clk) disable iff (areset_lane_template)
        mem_rsp_valid_i |-> mem_rsp_ready_o)
        else $error("mem_response_router: response pushed while not ready");

endmodule : mem_response_router

// File: hdl/lane_status.sv
`timescale 1ns/1ns
`include "lane_macros.svh"

module lane_status (
    input  logic                         ap_clk,
    input  logic                         areset_lane_template,
    input  logic [`LANE_NUM_ENGINES-1:0] eng_done_i,
    input  logic                         req_empty_i,
    input  logic                         rsp_empty_i,
    input  logic                         read_issued_i,
    input  logic                         read_returned_i,
    output logic                         lane_done_o
);

    import lane_pkg::*;

    // Wide enough for any realistic number of reads in flight
    localparam int CNT_W = 16;

    logic [CNT_W-1:0] outstanding_q;
    logic             done_cond;

    // -------------------------------------------------------------------
    // Reads in flight
    // -------------------------------------------------------------------
    // Issue and return in one cycle cancel out
    always_ff @(posedge ap_clk) begin
        if (areset_lane_template) begin
            outstanding_q <= '0;
        end else begin
            case ({read_issued_i, read_returned_i})
                2'b10:   outstanding_q <= outstanding_q + 1'b1;
                2'b01:   outstanding_q <= outstanding_q - 1'b1;
                default: outstanding_q <= outstanding_q;
            endcase
        end
    end

    // -------------------------------------------------------------------
    // Done level
    // -------------------------------------------------------------------
    assign done_cond = (&eng_done_i) & req_empty_i & rsp_empty_i & (outstanding_q == '0);

    always_ff @(posedge ap_clk) begin
        if (areset_lane_template) begin
            lane_done_o <= 1'b0;
        end else begin
            lane_done_o <= done_cond;
        end
    end

    // A return without a matching earlier issue means memory invented a read
    a_no_underflow: assert property (@(posedge ap_clk) disable iff (areset_lane_template)
        (read_returned_i && !read_issued_i) |-> (outstanding_q != '0))
        else $error("lane_status: read returned with none outstanding");

endmodule : lane_status

// File: hdl/lane_memory_hub.sv
`timescale 1ns/1ns
`include "lane_macros.svh"

module lane_memory_hub (
    input  logic                         ap_clk,
    input  logic                         areset_lane_template,

    // Engine requests
    input  logic [`LANE_NUM_ENGINES-1:0] eng_req_valid_i,
    input  lane_pkg::mem_packet_t        eng_req_packet_i [`LANE_NUM_ENGINES],
    output logic [`LANE_NUM_ENGINES-1:0] eng_req_pop_o,

    // Memory requests
    input  logic                         mem_req_ready_i,
    output logic                         mem_req_valid_o,
    output lane_pkg::mem_packet_t        mem_req_packet_o,

    // Memory responses
    input  logic                         mem_rsp_valid_i,
    input  lane_pkg::mem_packet_t        mem_rsp_packet_i,
    output logic                         mem_rsp_ready_o,

    // Engine responses
    input  logic [`LANE_NUM_ENGINES-1:0] eng_rsp_ready_i,
    output logic [`LANE_NUM_ENGINES-1:0] eng_rsp_valid_o,
    output lane_pkg::mem_packet_t        eng_rsp_packet_o,

    // Status
    input  logic [`LANE_NUM_ENGINES-1:0] eng_done_i,
    output logic                         lane_done_o
);

    import lane_pkg::*;

    logic req_empty;
    logic rsp_empty;
    logic read_issued;
    logic read_returned;

    // -------------------------------------------------------------------
    // Request path
    // -------------------------------------------------------------------
    mem_request_arbiter u_req_arb (
        .ap_clk              (ap_clk),
        .areset_lane_template(areset_lane_template),
        .eng_req_valid_i     (eng_req_valid_i),
        .eng_req_packet_i    (eng_req_packet_i),
        .eng_req_pop_o       (eng_req_pop_o),
        .mem_req_ready_i     (mem_req_ready_i),
        .mem_req_valid_o     (mem_req_valid_o),
        .mem_req_packet_o    (mem_req_packet_o),
        .req_empty_o         (req_empty),
        .read_issued_o       (read_issued)
    );

    // -------------------------------------------------------------------
    // Response path
    // -------------------------------------------------------------------
    mem_response_router u_rsp_router (
        .ap_clk              (ap_clk),
        .areset_lane_template(areset_lane_template),
        .mem_rsp_valid_i     (mem_rsp_valid_i),
        .mem_rsp_packet_i    (mem_rsp_packet_i),
        .mem_rsp_ready_o     (mem_rsp_ready_o),
        .eng_rsp_ready_i     (eng_rsp_ready_i),
        .eng_rsp_valid_o     (eng_rsp_valid_o),
        .eng_rsp_packet_o    (eng_rsp_packet_o),
        .rsp_empty_o         (rsp_empty),
        .read_returned_o     (read_returned)
    );

    // Combines engine done levels with both paths
    lane_status u_status (
        .ap_clk              (ap_clk),
        .areset_lane_template(areset_lane_template),
        .eng_done_i          (eng_done_i),
        .req_empty_i         (req_empty),
        .rsp_empty_i         (rsp_empty),
        .read_issued_i       (read_issued),
        .read_returned_i     (read_returned),
        .lane_done_o         (lane_done_o)
    );

endmodule : lane_memory_hub

// File: verif/lane_memory_hub_tb.sv
`timescale 1ns/1ns
`include "lane_macros.svh"

module lane_memory_hub_tb #(
    parameter logic [31:0] SEED = 32'h36de_14c4
);

    import lane_pkg::*;

    localparam int NUM_ENG        = `LANE_NUM_ENGINES;
    localparam int PKTS_PER_ENG   = 40;
    // One extra read re-opens the lane after the first done
    localparam int TOTAL_PKTS     = NUM_ENG * PKTS_PER_ENG + 1;
    localparam int TIMEOUT_CYCLES = 4 * TOTAL_PKTS + 200;
    localparam int RR_CYCLES      = 40;
    localparam int BP_START       = 140;
    localparam int BP_END         = 200;

    logic                 ap_clk;
    logic                 areset_lane_template;
    logic [NUM_ENG-1:0]   eng_req_valid_i;
    mem_packet_t          eng_req_packet_i [NUM_ENG];
    logic [NUM_ENG-1:0]   eng_req_pop_o;
    logic                 mem_req_ready_i;
    logic                 mem_req_valid_o;
    mem_packet_t          mem_req_packet_o;
    logic                 mem_rsp_valid_i;
    mem_packet_t          mem_rsp_packet_i;
    logic                 mem_rsp_ready_o;
    logic [NUM_ENG-1:0]   eng_rsp_ready_i;
    logic [NUM_ENG-1:0]   eng_rsp_valid_o;
    mem_packet_t          eng_rsp_packet_o;
    logic [NUM_ENG-1:0]   eng_done_i;
    logic                 lane_done_o;

    // Reference model
    mem_packet_t req_exp [NUM_ENG][$];
    mem_packet_t rsp_exp [NUM_ENG][$];
    mem_packet_t rsp_order [$];
    mem_packet_t rsp_pend [$];
    int          sent [NUM_ENG];
    int          budget [NUM_ENG];
    int          req_inflight;
    int          rsp_inflight;
    int          outstanding;
    int          cyc;
    int          stage;
    int          exp_idx;
    int          last_grant;
    int          timeout_cnt;
    logic        done_exp_q;
    logic        req_ready_q;
    logic        after_reset;
    logic        budget_left;
    logic [31:0] rng_state = SEED;
    logic [31:0] r;
    mem_packet_t pkt;

    lane_memory_hub u_lane_memory_hub (
        .ap_clk              (ap_clk),
        .areset_lane_template(areset_lane_template),
        .eng_req_valid_i     (eng_req_valid_i),
        .eng_req_packet_i    (eng_req_packet_i),
        .eng_req_pop_o       (eng_req_pop_o),
        .mem_req_ready_i     (mem_req_ready_i),
        .mem_req_valid_o     (mem_req_valid_o),
        .mem_req_packet_o    (mem_req_packet_o),
        .mem_rsp_valid_i     (mem_rsp_valid_i),
        .mem_rsp_packet_i    (mem_rsp_packet_i),
        .mem_rsp_ready_o     (mem_rsp_ready_o),
        .eng_rsp_ready_i     (eng_rsp_ready_i),
        .eng_rsp_valid_o     (eng_rsp_valid_o),
        .eng_rsp_packet_o    (eng_rsp_packet_o),
        .eng_done_i          (eng_done_i),
        .lane_done_o         (lane_done_o)
    );

    initial ap_clk = 1'b0;
    always #2 ap_clk = ~ap_clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] rand_word();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic mem_packet_t make_packet(input logic force_read);
        mem_packet_t p;
        logic [31:0] w;
        w      = rand_word();
        p.id   = engine_id_t'(w >> 8);
        p.cmd  = force_read ? MEM_CMD_READ : mem_cmd_e'(w[0]);
        p.addr = rand_word();
        p.data = rand_word();
        return p;
    endfunction

    // First valid engine after the last winner or -1 if none
    function automatic int rr_pick(input logic [NUM_ENG-1:0] valid, input int last);
        int idx;
        for (int off = 1; off <= NUM_ENG; off++) begin
            idx = (last + off) % NUM_ENG;
            if (valid[idx]) return idx;
        end
        return -1;
    endfunction

    task automatic check_packet(input mem_packet_t expected, input mem_packet_t actual,
                                input string what);
        if (actual !== expected) begin
            $display("ERR %0t ns: %s expected %h got %h", $time, what, expected, actual);
            $display("CHECKS FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic check_bit(input logic expected, input logic actual, input string what);
        if (actual !== expected) begin
            $display("ERR %0t ns: %s expected %b got %b", $time, what, expected, actual);
            $display("CHECKS FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic abort_run(input string reason);
        $display("Error at %0t ns: %s", $time, reason);
        $display("CHECKS FAILED");
        $fatal(1, "stopped on protocol error");
    endtask

    initial begin
        areset_lane_template = 1'b1;
        eng_req_valid_i      = '0;
        for (int k = 0; k < NUM_ENG; k++) eng_req_packet_i[k] = '0;
        mem_req_ready_i      = 1'b0;
        mem_rsp_valid_i      = 1'b0;
        mem_rsp_packet_i     = '0;
        eng_rsp_ready_i      = '0;
        eng_done_i           = '0;
        repeat (3) @(posedge ap_clk);
        areset_lane_template <= 1'b0;
    end

    always @(posedge ap_clk) begin
        if (areset_lane_template) begin
            for (int k = 0; k < NUM_ENG; k++) begin
                sent[k]   = 0;
                budget[k] = PKTS_PER_ENG;
            end
            req_inflight = 0;
            rsp_inflight = 0;
            outstanding  = 0;
            cyc          = 0;
            stage        = 0;
            last_grant   = NUM_ENG - 1;
            done_exp_q   = 1'b0;
            req_ready_q  = 1'b0;
            after_reset  = 1'b1;
        end else begin
            if (after_reset) begin
                check_bit(1'b1, mem_rsp_ready_o, "mem_rsp_ready_o after reset");
                check_bit(1'b0, mem_req_valid_o | (|eng_rsp_valid_o), "valids after reset");
                after_reset = 1'b0;
            end
            // -------------------------------------------------------------------
            // Done level lags its condition by one cycle
            // -------------------------------------------------------------------
            check_bit(done_exp_q, lane_done_o, "lane_done_o");
            done_exp_q = (&eng_done_i) && !(|eng_req_valid_i) && req_inflight == 0
                         && rsp_inflight == 0 && outstanding == 0;

            // Grants
            exp_idx = rr_pick(eng_req_valid_i, last_grant);
            if (|eng_req_pop_o) begin
                for (int k = 0; k < NUM_ENG; k++)
                    check_bit(k == exp_idx, eng_req_pop_o[k], "round-robin grant");
                pkt    = eng_req_packet_i[exp_idx];
                pkt.id = engine_id_t'(exp_idx);
                req_exp[exp_idx].push_back(pkt);
                sent[exp_idx]++;
                req_inflight++;
                last_grant = exp_idx;
            end else if (cyc < RR_CYCLES && (&eng_req_valid_i)) begin
                abort_run("no grant although every engine was valid and memory ready");
            end

            // Each read sent to memory becomes a pending response
            if (mem_req_valid_o) begin
                check_bit(1'b1, req_ready_q, "mem_req_ready_i in the cycle before valid");
                if (req_exp[mem_req_packet_o.id].size() == 0)
                    abort_run("memory request that no engine handed over");
                check_packet(req_exp[mem_req_packet_o.id].pop_front(), mem_req_packet_o,
                             "memory request");
                req_inflight--;
                if (mem_req_packet_o.cmd == MEM_CMD_READ) begin
                    outstanding++;
                    pkt      = mem_req_packet_o;
                    pkt.data = rand_word();
                    rsp_pend.push_back(pkt);
                end
            end
            req_ready_q = mem_req_ready_i;

            // Responses toward engines
            check_bit(1'b1, $onehot0(eng_rsp_valid_o), "eng_rsp_valid_o one-hot");
            for (int k = 0; k < NUM_ENG; k++) begin
                if (eng_rsp_valid_o[k]) begin
                    check_bit(1'b1, eng_rsp_ready_i[k], "ready of the target engine");
                    if (rsp_exp[k].size() == 0)
                        abort_run("response delivered to an engine with nothing pending");
                    check_packet(rsp_exp[k].pop_front(), eng_rsp_packet_o, "engine response");
                    check_packet(rsp_order.pop_front(), eng_rsp_packet_o, "response order");
                    rsp_inflight--;
                    if (eng_rsp_packet_o.cmd == MEM_CMD_READ) outstanding--;
                end
            end

            budget_left = 1'b0;
            for (int k = 0; k < NUM_ENG; k++) begin
                if (sent[k] < budget[k]) budget_left = 1'b1;
            end
            case (stage)
                0: if (!budget_left) stage = 1;
                1: if (lane_done_o) begin
                    stage = 2;
                    budget[0]++;
                end
                2: if (!lane_done_o) stage = 3;
                default: ;
            endcase

            // -------------------------------------------------------------------
            // Stimulus for the next cycle
            // -------------------------------------------------------------------
            for (int k = 0; k < NUM_ENG; k++) begin
                r = rand_word();
                if (!(eng_req_valid_i[k] && !eng_req_pop_o[k])) begin
                    if (sent[k] < budget[k] && (cyc < RR_CYCLES || stage >= 2 || r[0])) begin
                        eng_req_valid_i[k]  <= 1'b1;
                        eng_req_packet_i[k] <= make_packet(stage >= 2);
                    end else begin
                        eng_req_valid_i[k] <= 1'b0;
                    end
                end
            end
            r = rand_word();
            if (stage > 0 || cyc < RR_CYCLES) mem_req_ready_i <= 1'b1;
            else if (cyc >= BP_START && cyc < BP_END) mem_req_ready_i <= 1'b0;
            else mem_req_ready_i <= (r[31:30] != 2'b00);
            eng_rsp_ready_i <= (stage > 0) ? '1 : (r[NUM_ENG-1:0] | r[2*NUM_ENG-1:NUM_ENG]);
            eng_done_i      <= (stage > 0) ? '1 : r[3*NUM_ENG-1:2*NUM_ENG];
            // Idle cycle between offers keeps the FIFO below its threshold
            if (mem_rsp_ready_o && !mem_rsp_valid_i && rsp_pend.size() > 0
                && r[29:28] != 2'b00) begin
                pkt = rsp_pend.pop_front();
                rsp_exp[pkt.id].push_back(pkt);
                rsp_order.push_back(pkt);
                rsp_inflight++;
                mem_rsp_valid_i  <= 1'b1;
                mem_rsp_packet_i <= pkt;
            end else begin
                mem_rsp_valid_i <= 1'b0;
            end
            cyc++;

            if (stage == 3 && lane_done_o) begin
                if (rsp_pend.size() != 0 || req_inflight != 0 || outstanding != 0) begin
                    $display("Run ended with packets still unaccounted for");
                    $display("CHECKS FAILED");
                    $fatal(1, "model not drained");
                end else begin
                    $display("ALL CHECKS PASSED");
                    $finish;
                end
            end
        end
    end

    always @(posedge ap_clk) begin
        if (areset_lane_template) begin
            timeout_cnt <= 0;
        end else begin
            timeout_cnt <= timeout_cnt + 1;
            if (timeout_cnt >= TIMEOUT_CYCLES) begin
                $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
                $display("CHECKS FAILED");
                $fatal(1, "timeout");
            end
        end
    end

endmodule : lane_memory_hub_tb

// File: list.f
+incdir+hdl
hdl/lane_pkg.sv
hdl/lane_sync_fifo.sv
hdl/mem_request_arbiter.sv
hdl/mem_response_router.sv
hdl/lane_status.sv
hdl/lane_memory_hub.sv
verif/lane_memory_hub_tb.sv

// File: Makefile
# Verilator build and run for the lane memory hub testbench

VERILATOR ?= verilator
TOP       ?= lane_memory_hub_tb
SEED      ?= 36de14c4
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

FILELIST  := list.f
SRCS      := $(filter-out +incdir+%,$(shell cat $(FILELIST)))
HDRS      := $(wildcard hdl/*.svh)
SIM       := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source, header or the file list changes
$(SIM): $(SRCS) $(HDRS) $(FILELIST) Makefile
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GSEED=32\'h$(SEED) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf $(BUILD_DIR)
